//--- verilog/cart_header_pkg.sv
// Cartridge header layout and per-title compatibility types
// Shared by the header region, region select and quirk lookup stages
// Offsets are byte addresses of 16-bit words in the downloaded image

package cart_header_pkg;

	//////////////////////////////
	// Region selection

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		PRIO_UEJ = 2'd0, // US>EU>JP
		PRIO_EUJ = 2'd1, // EU>US>JP
		PRIO_UJE = 2'd2, // US>JP>EU
		PRIO_JUE = 2'd3  // JP>US>EU
	} region_prio_e;

	typedef enum logic [1:0] {
		AUTO_EXT    = 2'd0, // Region taken from the image index
		AUTO_HEADER = 2'd1,
		AUTO_OFF    = 2'd2
	} auto_region_e;

	// Regions listed in the header
	typedef struct packed {
		logic e;
		logic u;
		logic j;
	} region_flags_t;

	//////////////////////////////
	// Title quirks

	typedef struct packed {
		logic       sram;
		logic       eeprom;
		logic       fifo;
		logic       noram;
		logic       pier;
		logic       svp;
		logic       fmbusy;
		logic       schan;
		logic       gun_type;  // Light-gun model
		logic [7:0] gun_delay; // Sensor delay
	} cart_quirks_t;

	localparam int unsigned HDR_REGION0_ADDR  = 'h1F0;
	localparam int unsigned HDR_REGION1_ADDR  = 'h1F2;
	localparam int unsigned HDR_END_ADDR      = 'h200;
	localparam int unsigned SERIAL_FIRST_ADDR = 'h182;
	localparam int unsigned SERIAL_LAST_ADDR  = 'h18A;
	localparam int unsigned SERIAL_DONE_ADDR  = 'h18C;

	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

endpackage

//--- verilog/load_stream_pkg.sv
// Download stream and memory write records
// The host stream carries byte address, data word and image index
// Cheat downloads arrive on their own image index

package load_stream_pkg;

	localparam int ADDR_W = 25; // Byte address width

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       data;
		logic [7:0]        index;
	} dl_word_t;

	// Word-addressed write to ROM memory
	typedef struct packed {
		logic [ADDR_W-2:0] addr;
		logic [15:0]       data;
		logic              req_toggle;
	} rom_wr_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	localparam logic [7:0] CODE_INDEX = 8'hFF;

endpackage

//--- verilog/header_region_detect.sv
// Scans the cartridge header for its region characters
// Flags are rebuilt on every cartridge download, hdr_ready marks
// the end of the header and stays high until the download ends

`timescale 1ns/1ns

module header_region_detect (
	input  logic                            clk_sys,
	input  logic                            RESET,
	input  logic                            cart_dl,
	input  logic                            wr,
	input  load_stream_pkg::dl_word_t       dl,
	output cart_header_pkg::region_flags_t  flags,
	output logic                            hdr_ready
);

	logic                           cart_dl_q;
	logic [7:0]                     lo_char;
	logic [7:0]                     hi_char;
	logic [3:0]                     hex_val;
	cart_header_pkg::region_flags_t flags_d;

	assign lo_char = dl.data[7:0];
	assign hi_char = dl.data[15:8];
	assign hex_val = lo_char[3:0] - 4'd7; // 'A'..'F' low nibble to 10..15

	// Sets the flag of a J, U or E character
	function automatic cart_header_pkg::region_flags_t mark_letter(
		input cart_header_pkg::region_flags_t f,
		input logic [7:0]                     c
	);
		cart_header_pkg::region_flags_t r;
		r = f;
		case (c)
			"J": r.j = 1'b1;
			"U": r.u = 1'b1;
			"E": r.e = 1'b1;
			default: ;
		endcase
		return r;
	endfunction

	always_comb begin
		flags_d = flags;
		if (dl.addr == cart_header_pkg::HDR_REGION0_ADDR) begin
			if (lo_char inside {"J", "U", "E"})
				flags_d = mark_letter(flags_d, lo_char);
			else if (lo_char >= "0" && lo_char <= "9")
				flags_d = '{e: lo_char[3], u: lo_char[2], j: lo_char[0]}; // Hex region code
			else if (lo_char >= "A" && lo_char <= "F")
				flags_d = '{e: hex_val[3], u: hex_val[2], j: hex_val[0]};
			flags_d = mark_letter(flags_d, hi_char);
		end
		if (dl.addr == cart_header_pkg::HDR_REGION1_ADDR)
			flags_d = mark_letter(flags_d, lo_char);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			flags     <= '0;
			hdr_ready <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl & ~cart_dl_q)
				flags <= '0; // New image
			else if (cart_dl & wr)
				flags <= flags_d;

			if (cart_dl_q & ~cart_dl)
				hdr_ready <= 1'b0;
			else if (cart_dl & wr && dl.addr == cart_header_pkg::HDR_END_ADDR)
				hdr_ready <= 1'b1;
		end
	end

endmodule

//--- verilog/region_select.sv
// Chooses the console region once the header has been read
// Header mode follows the priority order, extension mode uses the
// image index, and the disabled mode leaves the request alone

`timescale 1ns/1ns

module region_select (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic                           hdr_ready,
	input  cart_header_pkg::region_flags_t flags,
	input  logic [7:0]                     index,
	input  cart_header_pkg::auto_region_e  auto_mode,
	input  cart_header_pkg::region_prio_e  prio,
	output cart_header_pkg::region_e       region_req,
	output logic                           region_set
);

	logic ready_q;

	function automatic logic region_seen(
		input cart_header_pkg::region_flags_t f,
		input cart_header_pkg::region_e       r
	);
		case (r)
			cart_header_pkg::REGION_JP: return f.j;
			cart_header_pkg::REGION_US: return f.u;
			cart_header_pkg::REGION_EU: return f.e;
			default: return 1'b0;
		endcase
	endfunction

	// First flagged region in priority order, else the order's head
	function automatic cart_header_pkg::region_e pick_region(
		input cart_header_pkg::region_flags_t f,
		input cart_header_pkg::region_prio_e  p
	);
		cart_header_pkg::region_e order [3];
		case (p)
			cart_header_pkg::PRIO_UEJ: order = '{cart_header_pkg::REGION_US,
				cart_header_pkg::REGION_EU, cart_header_pkg::REGION_JP};
			cart_header_pkg::PRIO_EUJ: order = '{cart_header_pkg::REGION_EU,
				cart_header_pkg::REGION_US, cart_header_pkg::REGION_JP};
			cart_header_pkg::PRIO_UJE: order = '{cart_header_pkg::REGION_US,
				cart_header_pkg::REGION_JP, cart_header_pkg::REGION_EU};
			default: order = '{cart_header_pkg::REGION_JP,
				cart_header_pkg::REGION_US, cart_header_pkg::REGION_EU};
		endcase
		if (region_seen(f, order[1]) && !region_seen(f, order[0]))
			return order[1];
		if (region_seen(f, order[2]) && !region_seen(f, order[0]) && !region_seen(f, order[1]))
			return order[2];
		return order[0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= cart_header_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (hdr_ready & ~ready_q) begin
				case (auto_mode)
					cart_header_pkg::AUTO_HEADER: begin
						region_req <= pick_region(flags, prio);
						region_set <= 1'b1;
					end
					cart_header_pkg::AUTO_EXT: begin
						region_req <= cart_header_pkg::region_e'(index[7:6]);
						region_set <= |index; // Plain extension gives index 0
					end
					default: ;
				endcase
			end else if (~hdr_ready & ready_q) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/cart_quirk_lookup.sv
// Reads the serial number from the cartridge header and looks it up
// in the table of titles that need compatibility quirks or a
// specific light-gun model and sensor delay

`timescale 1ns/1ns

module cart_quirk_lookup (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_dl,
	input  logic                          wr,
	input  load_stream_pkg::dl_word_t     dl,
	output cart_header_pkg::cart_quirks_t quirks
);

	logic                          wr_cart;
	logic                          cart_dl_q;
	logic [63:0]                   serial; // Eight ASCII characters
	cart_header_pkg::cart_quirks_t hit;

	assign wr_cart = cart_dl & wr;

	//////////////////////////////
	// Serial number capture

	always_ff @(posedge clk_sys) begin
		if (wr_cart) begin
			if (dl.addr == cart_header_pkg::SERIAL_FIRST_ADDR)
				serial[63:56] <= dl.data[15:8]; // Odd byte only
			else if (dl.addr == cart_header_pkg::SERIAL_FIRST_ADDR + 2)
				serial[55:40] <= {dl.data[7:0], dl.data[15:8]};
			else if (dl.addr == cart_header_pkg::SERIAL_FIRST_ADDR + 4)
				serial[39:24] <= {dl.data[7:0], dl.data[15:8]};
			else if (dl.addr == cart_header_pkg::SERIAL_FIRST_ADDR + 6)
				serial[23:8] <= {dl.data[7:0], dl.data[15:8]};
			else if (dl.addr == cart_header_pkg::SERIAL_LAST_ADDR)
				serial[7:0] <= dl.data[7:0];
		end
	end

	//////////////////////////////
	// Title table

	always_comb begin
		hit = '{gun_delay: cart_header_pkg::GUN_DELAY_DEFAULT, default: '0};
		case (serial)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				hit.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				hit.eeprom = 1'b1; // Serial EEPROM saves
			"T-113016": hit.noram = 1'b1; // Fails a fake RAM check
			"T-89016 ": hit.fifo = 1'b1;
			"T-574023", "T-574013": hit.pier = 1'b1;
			"MK-1229 ", "G-7001  ": hit.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": hit.fmbusy = 1'b1;
			"T-68???-": hit.schan = 1'b1;
			default: ;
		endcase

		// Light-gun titles
		case (serial)
			"MK-1533 ": hit.gun_delay = 8'd100;
			"T-95096-": begin
				hit.gun_type  = 1'b1;
				hit.gun_delay = 8'd52;
			end
			"T-95136-": begin
				hit.gun_type  = 1'b1;
				hit.gun_delay = 8'd30;
			end
			"MK-1658 ": hit.gun_delay = 8'd120;
			"T-081156": hit.gun_delay = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			quirks    <= '{gun_delay: cart_header_pkg::GUN_DELAY_DEFAULT, default: '0};
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl & ~cart_dl_q)
				quirks <= '{gun_type: quirks.gun_type, gun_delay: quirks.gun_delay, default: '0};
			else if (wr_cart && dl.addr == cart_header_pkg::SERIAL_DONE_ADDR)
				quirks <= hit;
		end
	end

endmodule

//--- verilog/cheat_code_loader.sv
// Builds cheat code records from the code download
// Each record is 16 bytes: flags, address, compare and replace,
// every field sent low word first

`timescale 1ns/1ns

module cheat_code_loader (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         code_dl,
	input  logic                         wr,
	input  load_stream_pkg::dl_word_t    dl,
	output load_stream_pkg::cheat_code_t code,
	output logic                         code_valid,
	output logic                         code_reset
);

	logic wr_code;

	assign wr_code = code_dl & wr;

	// Record fields by offset within the 16-byte slot
	always_ff @(posedge clk_sys) begin
		if (wr_code) begin
			case (dl.addr[3:0])
				4'd0:  code.flags[15:0]    <= dl.data;
				4'd2:  code.flags[31:16]   <= dl.data;
				4'd4:  code.addr[15:0]     <= dl.data;
				4'd6:  code.addr[31:16]    <= dl.data;
				4'd8:  code.compare[15:0]  <= dl.data;
				4'd10: code.compare[31:16] <= dl.data;
				4'd12: code.replace[15:0]  <= dl.data;
				4'd14: code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= wr_code && dl.addr[3:0] == 4'd14; // Last word of a record
			code_reset <= wr_code && dl.addr == '0;
		end
	end

endmodule

//--- verilog/rom_write_pacer.sv
// Forwards cartridge words to ROM memory over a toggle handshake
// The host is held off with wait_host until memory acknowledges,
// and the last address of the download is kept as the image size

`timescale 1ns/1ns

module rom_write_pacer (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                cart_dl,
	input  logic                                wr,
	input  load_stream_pkg::dl_word_t           dl,
	input  logic                                rom_ack,
	output logic                                wait_host,
	output load_stream_pkg::rom_wr_t            rom,
	output logic [load_stream_pkg::ADDR_W-1:0]  rom_size
);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} pacer_state_e;

	pacer_state_e                         state;
	logic                                 accept;
	logic                                 req_q;
	logic                                 cart_dl_q;
	logic [load_stream_pkg::ADDR_W-2:0]   waddr_q;
	logic [15:0]                          wdata_q;

	assign accept = cart_dl & wr;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state     <= ST_IDLE;
			req_q     <= 1'b0;
			cart_dl_q <= 1'b0;
			rom_size  <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (accept) begin
				state <= ST_WAIT;
				req_q <= ~req_q; // New request
			end else if (state == ST_WAIT && rom_ack == req_q) begin
				state <= ST_IDLE;
			end
			if (cart_dl_q & ~cart_dl)
				rom_size <= dl.addr; // End of download
		end
	end

	// Memory takes bytes in the opposite order
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			waddr_q <= dl.addr[load_stream_pkg::ADDR_W-1:1];
			wdata_q <= {dl.data[7:0], dl.data[15:8]};
		end
	end

	assign wait_host = (state == ST_WAIT);
	assign rom       = '{addr: waddr_q, data: wdata_q, req_toggle: req_q};

endmodule

//--- verilog/cart_loader_top.sv
// Cartridge loading path of the console core
// Splits the host download into cartridge and cheat streams and
// feeds the memory pacer, header, region, quirk and cheat blocks

`timescale 1ns/1ns

module cart_loader_top (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                download,
	input  logic                                wr,
	input  load_stream_pkg::dl_word_t           dl,
	input  logic                                rom_ack,
	input  cart_header_pkg::auto_region_e       auto_mode,
	input  cart_header_pkg::region_prio_e       prio,
	output logic                                wait_host,
	output load_stream_pkg::rom_wr_t            rom,
	output logic [load_stream_pkg::ADDR_W-1:0]  rom_size,
	output cart_header_pkg::region_e            region_req,
	output logic                                region_set,
	output cart_header_pkg::cart_quirks_t       quirks,
	output load_stream_pkg::cheat_code_t        code,
	output logic                                code_valid,
	output logic                                code_reset
);

	logic                           code_index;
	logic                           cart_dl;
	logic                           code_dl;
	logic                           hdr_ready;
	cart_header_pkg::region_flags_t hdr_flags;

	//////////////////////////////
	// Stream split

	assign code_index = (dl.index == load_stream_pkg::CODE_INDEX);
	assign cart_dl    = download & ~code_index;
	assign code_dl    = download & code_index;

	rom_write_pacer u_pacer (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.cart_dl  (cart_dl),
		.wr       (wr),
		.dl       (dl),
		.rom_ack  (rom_ack),
		.wait_host(wait_host),
		.rom      (rom),
		.rom_size (rom_size)
	);

	header_region_detect u_header (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.cart_dl  (cart_dl),
		.wr       (wr),
		.dl       (dl),
		.flags    (hdr_flags),
		.hdr_ready(hdr_ready)
	);

	region_select u_region (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.hdr_ready (hdr_ready),
		.flags     (hdr_flags),
		.index     (dl.index),
		.auto_mode (auto_mode),
		.prio      (prio),
		.region_req(region_req),
		.region_set(region_set)
	);

	cart_quirk_lookup u_quirks (
		.clk_sys(clk_sys),
		.RESET  (RESET),
		.cart_dl(cart_dl),
		.wr     (wr),
		.dl     (dl),
		.quirks (quirks)
	);

	cheat_code_loader u_cheats (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.code_dl   (code_dl),
		.wr        (wr),
		.dl        (dl),
		.code      (code),
		.code_valid(code_valid),
		.code_reset(code_reset)
	);

endmodule

//--- verification/cart_loader_props.sv
// Handshake and pulse properties of the cartridge loader
// Bound into the loader top level, next to the DUT's own signals

`timescale 1ns/1ns

module cart_loader_props (
	input logic                     clk_sys,
	input logic                     RESET,
	input logic                     wait_host,
	input load_stream_pkg::rom_wr_t rom,
	input logic                     rom_ack,
	input logic                     hdr_ready,
	input logic                     region_set,
	input logic                     code_valid
);

	int fail_count = 0; // Failed property evaluations

	// Host released only once memory has caught up
	a_wait_release: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(wait_host) |-> $past(rom.req_toggle == rom_ack))
		else begin
			fail_count++;
			$error("wait_host fell with a memory request outstanding");
		end

	a_code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else begin
			fail_count++;
			$error("code_valid held for more than one cycle");
		end

	// region_set trails hdr_ready by one cycle on both edges
	a_region_window: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> hdr_ready || $past(hdr_ready))
		else begin
			fail_count++;
			$error("region_set high outside the header window");
		end

endmodule

bind cart_loader_top cart_loader_props u_props (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.wait_host (wait_host),
	.rom       (rom),
	.rom_ack   (rom_ack),
	.hdr_ready (hdr_ready),
	.region_set(region_set),
	.code_valid(code_valid)
);

//--- verification/cart_loader_tb.sv
// Testbench for the cartridge loading path
// Streams one header image per table row, models ROM memory with
// random acknowledge delays, then loads two cheat code records

`timescale 1ns/1ns

module cart_loader_tb;

	typedef struct packed {
		logic [63:0]                   serial;
		logic [15:0]                   hdr0;   // High byte sits at the odd address
		logic [15:0]                   hdr1;
		logic [7:0]                    index;
		cart_header_pkg::auto_region_e mode;
		cart_header_pkg::region_prio_e prio;
		cart_header_pkg::region_e      exp_region;
		logic                          exp_set;
		cart_header_pkg::cart_quirks_t exp_quirks;
	} row_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} mem_word_t;

	logic                               clk_sys;
	logic                               RESET;
	logic                               download;
	logic                               wr;
	load_stream_pkg::dl_word_t          dl;
	logic                               rom_ack;
	cart_header_pkg::auto_region_e      auto_mode;
	cart_header_pkg::region_prio_e      prio;
	logic                               wait_host;
	load_stream_pkg::rom_wr_t           rom;
	logic [load_stream_pkg::ADDR_W-1:0] rom_size;
	cart_header_pkg::region_e           region_req;
	logic                               region_set;
	cart_header_pkg::cart_quirks_t      quirks;
	load_stream_pkg::cheat_code_t       code;
	logic                               code_valid;
	logic                               code_reset;

	row_t      rows[$];
	mem_word_t mem_expect[$]; // Words sent and not yet seen by memory
	int        errors = 0;
	int        checks = 0;
	int        words_sent = 0;
	int        mem_writes = 0;

	cart_loader_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Compare tasks

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_region(input string name, input cart_header_pkg::region_e got,
			input cart_header_pkg::region_e want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s got %s expected %s", $time, name,
				got.name(), want.name());
		end
	endtask

	task automatic check_quirks(input string name, input cart_header_pkg::cart_quirks_t got,
			input cart_header_pkg::cart_quirks_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_code(input string name, input load_stream_pkg::cheat_code_t got,
			input load_stream_pkg::cheat_code_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		$display("Simulation FAILED");
		$finish;
	endtask

	//////////////////////////////
	// Stimulus helpers

	function automatic cart_header_pkg::cart_quirks_t default_quirks();
		return {9'd0, cart_header_pkg::GUN_DELAY_DEFAULT};
	endfunction

	// Byte of the cartridge image at a byte address
	function automatic logic [7:0] image_byte(input row_t r, input int a);
		if (a > cart_header_pkg::SERIAL_FIRST_ADDR && a <= cart_header_pkg::SERIAL_LAST_ADDR)
			return r.serial[8 * (cart_header_pkg::SERIAL_LAST_ADDR - a) +: 8];
		case (a)
			cart_header_pkg::HDR_REGION0_ADDR:     return r.hdr0[7:0];
			cart_header_pkg::HDR_REGION0_ADDR + 1: return r.hdr0[15:8];
			cart_header_pkg::HDR_REGION1_ADDR:     return r.hdr1[7:0];
			cart_header_pkg::HDR_REGION1_ADDR + 1: return r.hdr1[15:8];
			default: return 8'(a ^ (a >> 8) ^ 'h3C); // Filler from the whole address
		endcase
	endfunction

	task automatic add_row(input logic [63:0] serial, input logic [15:0] hdr0,
			input logic [15:0] hdr1, input logic [7:0] index,
			input cart_header_pkg::auto_region_e mode, input cart_header_pkg::region_prio_e prio,
			input cart_header_pkg::region_e exp_region, input logic exp_set,
			input logic [7:0] qmask, input logic gun_type, input logic [7:0] gun_delay);
		row_t r;
		r = '{serial, hdr0, hdr1, index, mode, prio, exp_region, exp_set,
			cart_header_pkg::cart_quirks_t'({qmask, gun_type, gun_delay})};
		rows.push_back(r);
	endtask

	// Quirk mask order is sram eeprom fifo noram pier svp fmbusy schan
	task automatic fill_table();
		add_row("T-081276", {"U", "J"}, {" ", "E"}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_US, 1'b1, 8'b1000_0000, 1'b0, 8'd44);
		add_row("MK-1215 ", {" ", "J"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_EUJ, cart_header_pkg::REGION_JP, 1'b1, 8'b0100_0000, 1'b0, 8'd44);
		add_row("MK-1229 ", {" ", "4"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_JUE, cart_header_pkg::REGION_US, 1'b1, 8'b0000_0100, 1'b0, 8'd44);
		add_row("MK-1533 ", {" ", "8"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_UJE, cart_header_pkg::REGION_EU, 1'b1, 8'h00, 1'b0, 8'd100);
		add_row("T-95096-", {" ", "D"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_JUE, cart_header_pkg::REGION_JP, 1'b1, 8'h00, 1'b1, 8'd52);
		add_row("T-95136-", {" ", "A"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_EU, 1'b1, 8'h00, 1'b1, 8'd30);
		add_row("MK-1658 ", {" ", " "}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_EUJ, cart_header_pkg::REGION_EU, 1'b1, 8'h00, 1'b0, 8'd120);
		add_row("T-081156", {" ", " "}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_JUE, cart_header_pkg::REGION_JP, 1'b1, 8'h00, 1'b0, 8'd126);
		add_row("T-99999 ", {" ", "J"}, {" ", " "}, 8'h40, cart_header_pkg::AUTO_EXT,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_US, 1'b1, 8'h00, 1'b0, 8'd44);
		add_row("G-4060  ", {" ", "U"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_EXT,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_JP, 1'b0, 8'b0100_0000, 1'b0, 8'd44);
		add_row("T-89016 ", {" ", "J"}, {" ", " "}, 8'h85, cart_header_pkg::AUTO_EXT,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_EU, 1'b1, 8'b0010_0000, 1'b0, 8'd44);
		// Disabled mode keeps the previous region
		add_row("T-574023", {" ", "J"}, {" ", " "}, 8'h40, cart_header_pkg::AUTO_OFF,
			cart_header_pkg::PRIO_UEJ, cart_header_pkg::REGION_EU, 1'b0, 8'b0000_1000, 1'b0, 8'd44);
		add_row("T-35036 ", {"E", "U"}, {" ", " "}, 8'h00, cart_header_pkg::AUTO_HEADER,
			cart_header_pkg::PRIO_JUE, cart_header_pkg::REGION_US, 1'b1, 8'b0000_0010, 1'b0, 8'd44);
	endtask

	// Called just after a falling edge, returns one cycle later with wr low
	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		wr      = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (wait_host && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (wait_host)
			report_timeout("wait_host to fall");
	endtask

	//////////////////////////////
	// Memory model

	initial begin : memory_model
		mem_word_t want;
		int        delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && rom.req_toggle !== rom_ack) begin
				mem_writes++;
				if (mem_expect.size() == 0) begin
					errors++;
					$display("Memory write to word %h with no word sent", rom.addr);
				end else begin
					want = mem_expect.pop_front();
					check_word("rom.addr", rom.addr[15:0], want.addr);
					check_word("rom.data", rom.data, want.data);
				end
				delay = $urandom % 6;
				repeat (delay) @(negedge clk_sys);
				rom_ack = rom.req_toggle;
			end
		end
	end

	//////////////////////////////
	// Test sequences

	task automatic load_cart_row(input int n);
		row_t                          r;
		cart_header_pkg::cart_quirks_t prev;
		mem_word_t                     m;
		int                            a;
		int                            err0;
		err0 = errors;
		r    = rows[n];
		prev = (n == 0) ? default_quirks() : rows[n - 1].exp_quirks;
		dl.index  = r.index;
		auto_mode = r.mode;
		prio      = r.prio;
		@(negedge clk_sys);
		download = 1'b1;
		@(negedge clk_sys);
		check_quirks("quirks", quirks, cart_header_pkg::cart_quirks_t'({8'h00, prev[8:0]}));
		for (a = 0; a <= cart_header_pkg::HDR_END_ADDR; a += 2) begin
			m.addr = 16'(a >> 1);
			m.data = {image_byte(r, a), image_byte(r, a + 1)}; // Memory byte order
			mem_expect.push_back(m);
			words_sent++;
			send_word(25'(a), {image_byte(r, a + 1), image_byte(r, a)});
			check_flag("wait_host", wait_host, 1'b1);
			if (a == cart_header_pkg::SERIAL_DONE_ADDR)
				check_quirks("quirks", quirks, r.exp_quirks);
			if (a == cart_header_pkg::HDR_END_ADDR) begin
				check_flag("region_set", region_set, 1'b0);
				@(negedge clk_sys);
				check_flag("region_set", region_set, r.exp_set);
				check_region("region_req", region_req, r.exp_region);
			end
			wait_ready();
		end
		download = 1'b0;
		@(negedge clk_sys);
		check_word("rom_size", rom_size[15:0], 16'(cart_header_pkg::HDR_END_ADDR));
		repeat (2) @(negedge clk_sys);
		check_flag("region_set", region_set, 1'b0);
		check_flag("wait_host", wait_host, 1'b0);
		if (mem_expect.size() != 0 || mem_writes != words_sent) begin
			errors++;
			$display("Memory saw %0d of %0d words sent", mem_writes, words_sent);
		end
		$display("Row %0d serial %s mode %s: %0d errors", n, r.serial, r.mode.name(),
			errors - err0);
	endtask

	task automatic load_cheats();
		load_stream_pkg::cheat_code_t want;
		logic [15:0]                  word;
		int                           a;
		int                           writes0;
		int                           err0;
		err0    = errors;
		writes0 = mem_writes;
		want    = '0;
		dl.index = load_stream_pkg::CODE_INDEX;
		@(negedge clk_sys);
		download = 1'b1;
		@(negedge clk_sys);
		for (a = 0; a < 32; a += 2) begin
			word = 16'($urandom);
			// Fields flags, addr, compare, replace with the low half first
			want[96 - 32 * ((a % 16) / 4) + 16 * ((a / 2) % 2) +: 16] = word;
			send_word(25'(a), word);
			check_flag("code_reset", code_reset, a == 0);
			check_flag("code_valid", code_valid, a % 16 == 14);
			check_flag("wait_host", wait_host, 1'b0);
			if (a % 16 == 14)
				check_code("code", code, want);
			@(negedge clk_sys);
			check_flag("code_valid", code_valid, 1'b0);
			check_flag("code_reset", code_reset, 1'b0);
		end
		download = 1'b0;
		repeat (8) @(negedge clk_sys);
		if (mem_writes != writes0) begin
			errors++;
			$display("Cheat download caused %0d memory writes", mem_writes - writes0);
		end
		$display("Cheat records: %0d errors", errors - err0);
	endtask

	initial begin : main
		int err0;
		void'($urandom(69));
		RESET     = 1'b1;
		download  = 1'b0;
		wr        = 1'b0;
		dl        = '0;
		auto_mode = cart_header_pkg::AUTO_HEADER;
		prio      = cart_header_pkg::PRIO_UEJ;
		fill_table();
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;

		err0 = errors;
		check_flag("wait_host", wait_host, 1'b0);
		check_flag("region_set", region_set, 1'b0);
		check_flag("code_valid", code_valid, 1'b0);
		check_flag("code_reset", code_reset, 1'b0);
		check_flag("rom.req_toggle", rom.req_toggle, 1'b0);
		check_quirks("quirks", quirks, default_quirks());
		$display("Reset state: %0d errors", errors - err0);

		for (int n = 0; n < rows.size(); n++)
			load_cart_row(n);
		load_cheats();

		// Bound property failures count as errors too
		$display("Handshake properties: %0d failures", dut.u_props.fail_count);
		errors += dut.u_props.fail_count;

		$display("Tests %0d, checks %0d, errors %0d", rows.size() + 2, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- cart_loader.f
verilog/cart_header_pkg.sv
verilog/load_stream_pkg.sv
verilog/header_region_detect.sv
verilog/region_select.sv
verilog/cart_quirk_lookup.sv
verilog/cheat_code_loader.sv
verilog/rom_write_pacer.sv
verilog/cart_loader_top.sv
verification/cart_loader_props.sv
verification/cart_loader_tb.sv

//--- Bender.yml
package:
  name: cart_loader

sources:
  - verilog/cart_header_pkg.sv
  - verilog/load_stream_pkg.sv
  - verilog/header_region_detect.sv
  - verilog/region_select.sv
  - verilog/cart_quirk_lookup.sv
  - verilog/cheat_code_loader.sv
  - verilog/rom_write_pacer.sv
  - verilog/cart_loader_top.sv
  - target: test
    files:
      - verification/cart_loader_props.sv
      - verification/cart_loader_tb.sv
